// ==== Makefile ====
TOP := tb_mcu_periph

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f rtl/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

lint:
	verilator --lint-only -Wall --top-module mcu_periph_top rtl/mcu_pkg.sv \
		rtl/periph_bus_ctrl.sv rtl/hpet_timer.sv rtl/int_confreg.sv \
		rtl/game_regs.sv rtl/mcu_periph_top.sv

clean:
	rm -rf obj_dir

// ==== rtl/game_regs.sv ====
`default_nettype none

module game_regs (
	input  wire                  clk_ext8m,
	input  wire                  RSTN,
	input  mcu_pkg::periph_req_t req_i,
	input  wire                  stb_i,
	output mcu_pkg::data_t       rdata_o,
	input  mcu_pkg::key_t        key_game_i,
	output logic                 key_int_o,
	output mcu_pkg::score_t      score_o
);

	mcu_pkg::key_t   key_meta_q;
	mcu_pkg::key_t   key_q;       // Second sync stage, read as KEY
	mcu_pkg::key_t   key_prev_q;
	mcu_pkg::key_t   edge_q;
	mcu_pkg::key_t   edge_clr;
	mcu_pkg::key_t   rise;
	mcu_pkg::score_t score_q;
	logic            wr;

	assign wr   = stb_i && req_i.we;
	assign rise = key_q & ~key_prev_q;
	assign edge_clr = (wr && req_i.idx == mcu_pkg::GAME_EDGE) ?
		req_i.wdata[$bits(mcu_pkg::key_t)-1:0] : '0;

	always_ff @(posedge clk_ext8m or negedge RSTN)
	begin
		if (!RSTN)
		begin
			key_meta_q <= '0;
			key_q      <= '0;
			key_prev_q <= '0;
			edge_q     <= '0;
			score_q    <= '0;
		end
		else
		begin
			key_meta_q <= key_game_i;  // Pins are asynchronous
			key_q      <= key_meta_q;
			key_prev_q <= key_q;
			edge_q     <= (edge_q & ~edge_clr) | rise;  // New edge survives a clear
			if (wr && req_i.idx == mcu_pkg::GAME_SCORE)
				score_q <= req_i.wdata;
		end
	end

	always_comb
	begin
		rdata_o = '0;
		case (req_i.idx)
			mcu_pkg::GAME_KEY:   rdata_o[$bits(mcu_pkg::key_t)-1:0] = key_q;
			mcu_pkg::GAME_EDGE:  rdata_o[$bits(mcu_pkg::key_t)-1:0] = edge_q;
			mcu_pkg::GAME_SCORE: rdata_o = score_q;
			default:             rdata_o = '0;
		endcase
	end

	assign key_int_o = |edge_q;
	assign score_o   = score_q;

endmodule

`default_nettype wire

// ==== rtl/hpet_timer.sv ====
`default_nettype none

module hpet_timer (
	input  wire                  clk_ext8m,
	input  wire                  RSTN,
	input  mcu_pkg::periph_req_t req_i,
	input  wire                  stb_i,
	output mcu_pkg::data_t       rdata_o,
	output logic                 timer_int_o
);

	logic [mcu_pkg::TMR_IRQ_EN_BIT:0] ctrl_q;
	mcu_pkg::data_t                   count_q;
	mcu_pkg::data_t                   compare_q;
	logic                             match_q;
	logic                             wr;
	logic                             enable;
	logic                             hit;

	assign wr     = stb_i && req_i.we;
	assign enable = ctrl_q[mcu_pkg::TMR_EN_BIT];
	assign hit    = enable && (count_q == compare_q);

	always_ff @(posedge clk_ext8m or negedge RSTN)
	begin
		if (!RSTN)
		begin
			ctrl_q    <= '0;
			count_q   <= '0;
			compare_q <= '0;
			match_q   <= 1'b0;
		end
		else
		begin
			if (wr && req_i.idx == mcu_pkg::TMR_CTRL)
				ctrl_q <= req_i.wdata[mcu_pkg::TMR_IRQ_EN_BIT:0];

			if (wr && req_i.idx == mcu_pkg::TMR_COUNT)
				count_q <= req_i.wdata;  // Software load beats the increment
			else if (enable)
				count_q <= count_q + 1'b1;

			if (wr && req_i.idx == mcu_pkg::TMR_COMPARE)
				compare_q <= req_i.wdata;

			// Sticky match, a new hit wins over the clear
			if (hit)
				match_q <= 1'b1;
			else if (wr && req_i.idx == mcu_pkg::TMR_STATUS && req_i.wdata[0])
				match_q <= 1'b0;
		end
	end

	always_comb
	begin
		rdata_o = '0;
		case (req_i.idx)
			mcu_pkg::TMR_CTRL:    rdata_o[mcu_pkg::TMR_IRQ_EN_BIT:0] = ctrl_q;
			mcu_pkg::TMR_COUNT:   rdata_o = count_q;
			mcu_pkg::TMR_COMPARE: rdata_o = compare_q;
			default:              rdata_o[0] = match_q;  // STATUS
		endcase
	end

	assign timer_int_o = match_q && ctrl_q[mcu_pkg::TMR_IRQ_EN_BIT];

endmodule

`default_nettype wire

// ==== rtl/int_confreg.sv ====
`default_nettype none

module int_confreg (
	input  wire                  clk_ext8m,
	input  wire                  RSTN,
	input  mcu_pkg::periph_req_t req_i,
	input  wire                  stb_i,
	output mcu_pkg::data_t       rdata_o,
	input  mcu_pkg::int_src_t    src_i,
	output logic                 int_o
);

	mcu_pkg::int_src_t mask_q;
	logic              mask_wr;

	assign mask_wr = stb_i && req_i.we && (req_i.idx == mcu_pkg::INT_MASK);

	// Only the implemented source bits are kept
	always_ff @(posedge clk_ext8m or negedge RSTN)
	begin
		if (!RSTN)
			mask_q <= '0;
		else if (mask_wr)
			mask_q <= req_i.wdata[mcu_pkg::NUM_INT_SRC-1:0];
	end

	// STATUS shows the live source levels, nothing is latched here
	always_comb
	begin
		rdata_o = '0;
		case (req_i.idx)
			mcu_pkg::INT_STATUS: rdata_o[mcu_pkg::NUM_INT_SRC-1:0] = src_i;
			mcu_pkg::INT_MASK:   rdata_o[mcu_pkg::NUM_INT_SRC-1:0] = mask_q;
			default:             rdata_o = '0;
		endcase
	end

	assign int_o = |(src_i & mask_q);  // Any enabled source

endmodule

`default_nettype wire

// ==== rtl/mcu_periph_top.sv ====
`default_nettype none

module mcu_periph_top (
	input  wire             clk_ext8m,
	input  wire             RSTN,

	input  wire             wb_cyc_i,
	input  wire             wb_stb_i,
	input  wire             wb_we_i,
	input  mcu_pkg::addr_t  wb_adr_i,
	input  mcu_pkg::data_t  wb_dat_i,
	output mcu_pkg::data_t  wb_dat_o,
	output wire             wb_ack_o,

	input  mcu_pkg::key_t   key_game_i,
	output wire             int_o,
	output mcu_pkg::score_t score_o
);

	mcu_pkg::periph_req_t req;
	mcu_pkg::data_t       tmr_rdata;
	mcu_pkg::data_t       int_rdata;
	mcu_pkg::data_t       game_rdata;
	wire                  tmr_stb;
	wire                  int_stb;
	wire                  game_stb;
	wire                  timer_int;
	wire                  key_int;

	// ------------------------------------------------------------
	// Bus controller
	// ------------------------------------------------------------
	periph_bus_ctrl u_bus_ctrl (
		.clk_ext8m    (clk_ext8m),
		.RSTN         (RSTN),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_we_i      (wb_we_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.req_o        (req),
		.tmr_stb_o    (tmr_stb),
		.int_stb_o    (int_stb),
		.game_stb_o   (game_stb),
		.tmr_rdata_i  (tmr_rdata),
		.int_rdata_i  (int_rdata),
		.game_rdata_i (game_rdata)
	);

	// ------------------------------------------------------------
	// Peripherals
	// ------------------------------------------------------------
	hpet_timer u_timer (
		.clk_ext8m   (clk_ext8m),
		.RSTN        (RSTN),
		.req_i       (req),
		.stb_i       (tmr_stb),
		.rdata_o     (tmr_rdata),
		.timer_int_o (timer_int)
	);

	int_confreg u_confreg (
		.clk_ext8m (clk_ext8m),
		.RSTN      (RSTN),
		.req_i     (req),
		.stb_i     (int_stb),
		.rdata_o   (int_rdata),
		.src_i     ({key_int, timer_int}),  // Bit 0 timer, bit 1 keys
		.int_o     (int_o)
	);

	game_regs u_game (
		.clk_ext8m  (clk_ext8m),
		.RSTN       (RSTN),
		.req_i      (req),
		.stb_i      (game_stb),
		.rdata_o    (game_rdata),
		.key_game_i (key_game_i),
		.key_int_o  (key_int),
		.score_o    (score_o)
	);

endmodule

`default_nettype wire

// ==== rtl/mcu_pkg.sv ====
`default_nettype none

package mcu_pkg;

	// ------------------------------------------------------------
	// Vector types
	// ------------------------------------------------------------
	typedef logic [7:0]  addr_t;     // Wishbone byte address
	typedef logic [31:0] data_t;
	typedef logic [1:0]  reg_idx_t;  // Word index inside a slave
	typedef logic [15:0] key_t;
	typedef logic [31:0] score_t;    // Four packed 8-bit scores

	localparam int NUM_INT_SRC = 2;
	typedef logic [NUM_INT_SRC-1:0] int_src_t;  // Bit 0 timer, bit 1 keys

	// ------------------------------------------------------------
	// Address map
	// ------------------------------------------------------------
	localparam int SLV_MSB = 7;
	localparam int SLV_LSB = 6;
	localparam int IDX_MSB = 3;
	localparam int IDX_LSB = 2;

	typedef enum logic [1:0] {
		SLV_TIMER   = 2'd0,
		SLV_CONFREG = 2'd1,
		SLV_GAME    = 2'd2,
		SLV_NONE    = 2'd3
	} slave_t;

	typedef enum logic {
		BUS_IDLE = 1'b0,
		BUS_ACK  = 1'b1
	} bus_state_t;

	// Timer registers
	localparam reg_idx_t TMR_CTRL    = 2'd0;
	localparam reg_idx_t TMR_COUNT   = 2'd1;
	localparam reg_idx_t TMR_COMPARE = 2'd2;
	localparam reg_idx_t TMR_STATUS  = 2'd3;

	localparam int TMR_EN_BIT     = 0;
	localparam int TMR_IRQ_EN_BIT = 1;

	// Interrupt block registers
	localparam reg_idx_t INT_STATUS = 2'd0;
	localparam reg_idx_t INT_MASK   = 2'd1;

	// Game block registers
	localparam reg_idx_t GAME_KEY   = 2'd0;
	localparam reg_idx_t GAME_EDGE  = 2'd1;
	localparam reg_idx_t GAME_SCORE = 2'd2;

	// One access as seen by every slave
	typedef struct packed {
		logic     we;
		reg_idx_t idx;
		data_t    wdata;
	} periph_req_t;

endpackage

`default_nettype wire

// ==== rtl/periph_bus_ctrl.sv ====
`default_nettype none

module periph_bus_ctrl (
	input  wire                 clk_ext8m,
	input  wire                 RSTN,

	input  wire                 wb_cyc_i,
	input  wire                 wb_stb_i,
	input  wire                 wb_we_i,
	input  mcu_pkg::addr_t      wb_adr_i,
	input  mcu_pkg::data_t      wb_dat_i,
	output mcu_pkg::data_t      wb_dat_o,
	output logic                wb_ack_o,

	output mcu_pkg::periph_req_t req_o,
	output logic                tmr_stb_o,
	output logic                int_stb_o,
	output logic                game_stb_o,
	input  mcu_pkg::data_t      tmr_rdata_i,
	input  mcu_pkg::data_t      int_rdata_i,
	input  mcu_pkg::data_t      game_rdata_i
);

	mcu_pkg::bus_state_t state_q;
	mcu_pkg::bus_state_t state_d;
	mcu_pkg::slave_t     slv;
	mcu_pkg::data_t      rdata_sel;
	logic                req_valid;

	assign req_valid = wb_cyc_i && wb_stb_i;
	assign slv       = mcu_pkg::slave_t'(wb_adr_i[mcu_pkg::SLV_MSB:mcu_pkg::SLV_LSB]);

	// Request is shared by all slaves, the strobe picks one
	assign req_o.we    = wb_we_i;
	assign req_o.idx   = wb_adr_i[mcu_pkg::IDX_MSB:mcu_pkg::IDX_LSB];
	assign req_o.wdata = wb_dat_i;

	// ------------------------------------------------------------
	// Handshake FSM
	// ------------------------------------------------------------
	always_comb
	begin
		state_d = mcu_pkg::BUS_IDLE;
		if (state_q == mcu_pkg::BUS_IDLE && req_valid)
			state_d = mcu_pkg::BUS_ACK;  // One wait cycle, then ack
	end

	always_ff @(posedge clk_ext8m or negedge RSTN)
	begin
		if (!RSTN)
			state_q <= mcu_pkg::BUS_IDLE;
		else
			state_q <= state_d;
	end

	assign wb_ack_o   = (state_q == mcu_pkg::BUS_ACK);
	assign tmr_stb_o  = wb_ack_o && (slv == mcu_pkg::SLV_TIMER);
	assign int_stb_o  = wb_ack_o && (slv == mcu_pkg::SLV_CONFREG);
	assign game_stb_o = wb_ack_o && (slv == mcu_pkg::SLV_GAME);

	// ------------------------------------------------------------
	// Read data return
	// ------------------------------------------------------------
	always_comb
	begin
		case (slv)
			mcu_pkg::SLV_TIMER:   rdata_sel = tmr_rdata_i;
			mcu_pkg::SLV_CONFREG: rdata_sel = int_rdata_i;
			mcu_pkg::SLV_GAME:    rdata_sel = game_rdata_i;
			default:              rdata_sel = '0;  // Unmapped reads as zero
		endcase
	end

	// Captured on the edge that raises ack
	always_ff @(posedge clk_ext8m or negedge RSTN)
	begin
		if (!RSTN)
			wb_dat_o <= '0;
		else if (state_q == mcu_pkg::BUS_IDLE && req_valid)
			wb_dat_o <= rdata_sel;
	end

endmodule

`default_nettype wire

// ==== tests/mcu_periph_assertions.sv ====
`default_nettype none

module mcu_periph_assertions (
	input wire                 clk_ext8m,
	input wire                 RSTN,
	input wire                 cyc_i,
	input wire                 stb_i,
	input wire                 ack_i
);
	timeunit 1ns;
	timeprecision 100ps;

	logic        req;
	int unsigned fail_cnt = 0;  // Failed properties so far

	assign req = cyc_i && stb_i;

	ack_in_cycle: assert property (@(posedge clk_ext8m) disable iff (!RSTN)
		ack_i |-> req)
	else
	begin
		fail_cnt++;
		$error("ack raised outside an active cyc and stb");
	end

	ack_single: assert property (@(posedge clk_ext8m) disable iff (!RSTN)
		ack_i |=> !ack_i)
	else
	begin
		fail_cnt++;
		$error("ack held high for two cycles");
	end

	// Fixed one cycle latency from an idle request
	ack_latency: assert property (@(posedge clk_ext8m) disable iff (!RSTN)
		(req && !ack_i) |=> ack_i)
	else
	begin
		fail_cnt++;
		$error("no ack one cycle after a request");
	end

endmodule

bind periph_bus_ctrl mcu_periph_assertions i_bus_assert (
	.clk_ext8m (clk_ext8m),
	.RSTN      (RSTN),
	.cyc_i     (wb_cyc_i),
	.stb_i     (wb_stb_i),
	.ack_i     (wb_ack_o)
);

`default_nettype wire

// ==== tests/mcu_periph_vectors.txt ====
// op addr data expect (hex); op 0 write, 1 read, 2 random write and readback with kept bits,
// 3 poll read (data is the retry limit), 4 drive keys, 5 check int_o, 6 check score_o, f end
1 00 00000000 00000000
1 04 00000000 00000000
1 08 00000000 00000000
1 0c 00000000 00000000
1 40 00000000 00000000
1 44 00000000 00000000
1 80 00000000 00000000
1 84 00000000 00000000
1 88 00000000 00000000
5 00 00000000 00000000
2 08 00000000 ffffffff
2 88 00000000 ffffffff
6 00 00000000 00000000
0 c8 12345678 00000000
1 c8 00000000 00000000
6 00 00000000 00000000
2 44 00000000 00000003
0 44 00000001 00000000
0 08 00000014 00000000
0 04 00000000 00000000
0 00 00000003 00000000
3 0c 00000040 00000001
5 00 00000000 00000001
0 0c 00000001 00000000
1 0c 00000000 00000000
5 00 00000000 00000000
0 00 00000000 00000000
0 44 00000003 00000000
4 00 0000a501 00000000
3 80 00000010 0000a501
1 84 00000000 0000a501
1 40 00000000 00000002
5 00 00000000 00000001
0 44 00000001 00000000
5 00 00000000 00000000
0 84 0000ffff 00000000
1 84 00000000 00000000
1 40 00000000 00000000
f 00 00000000 00000000

// ==== tests/tb_mcu_periph.sv ====
`default_nettype none

module tb_mcu_periph;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_VEC   = 64;
	localparam int ACK_LIMIT = 8;

	logic            clk_ext8m;
	logic            RSTN;
	logic            wb_cyc;
	logic            wb_stb;
	logic            wb_we;
	mcu_pkg::addr_t  wb_adr;
	mcu_pkg::data_t  wb_dat_w;
	mcu_pkg::data_t  wb_dat_r;
	logic            wb_ack;
	mcu_pkg::key_t   key_game;
	logic            int_irq;
	mcu_pkg::score_t score;

	mcu_pkg::data_t  vec_mem [0:4*MAX_VEC-1];  // Four words per vector
	logic [31:0]     lfsr_q;
	mcu_pkg::data_t  last_rand;

	mcu_periph_top i_dut (
		.clk_ext8m  (clk_ext8m),
		.RSTN       (RSTN),
		.wb_cyc_i   (wb_cyc),
		.wb_stb_i   (wb_stb),
		.wb_we_i    (wb_we),
		.wb_adr_i   (wb_adr),
		.wb_dat_i   (wb_dat_w),
		.wb_dat_o   (wb_dat_r),
		.wb_ack_o   (wb_ack),
		.key_game_i (key_game),
		.int_o      (int_irq),
		.score_o    (score)
	);

	initial
	begin
		clk_ext8m = 1'b0;
		forever
			#20 clk_ext8m = ~clk_ext8m;  // 25 MHz stand-in
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
	endfunction

	task automatic draw_word(output mcu_pkg::data_t w);
		for (int i = 0; i < 32; i++)
		begin
			lfsr_q = lfsr_step(lfsr_q);
			w[i]   = lfsr_q[0];
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input mcu_pkg::data_t expected,
		input mcu_pkg::data_t actual);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	// One Wishbone classic access with latency and ack width checks
	task automatic bus_access(input logic we, input mcu_pkg::addr_t adr,
		input mcu_pkg::data_t wdata, input string name, output mcu_pkg::data_t rdata);
		int waited;
		waited = 0;
		@(posedge clk_ext8m);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		@(negedge clk_ext8m);
		while (!wb_ack)
		begin
			waited++;
			if (waited > ACK_LIMIT)
				abort_run($sformatf("No ack from the DUT for the access to %h", adr));
			@(negedge clk_ext8m);
		end
		check_value({name, " ack latency"}, 32'd1, mcu_pkg::data_t'(waited));
		rdata = wb_dat_r;
		@(posedge clk_ext8m);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(negedge clk_ext8m);
		check_value({name, " ack width"}, '0, {31'b0, wb_ack});
	endtask

	task automatic poll_reg(input mcu_pkg::addr_t adr, input mcu_pkg::data_t expected,
		input int limit, input string name);
		int             tries;
		mcu_pkg::data_t rd;
		tries = 0;
		bus_access(1'b0, adr, '0, name, rd);
		while (rd !== expected)
		begin
			tries++;
			if (tries > limit)
				abort_run($sformatf("Register %h never reached %h in %s", adr, expected, name));
			bus_access(1'b0, adr, '0, name, rd);
		end
	endtask

	// ------------------------------------------------------------
	// Vector player
	// ------------------------------------------------------------
	initial
	begin
		int             n;
		bit             done;
		mcu_pkg::data_t op;
		mcu_pkg::addr_t adr;
		mcu_pkg::data_t dat;
		mcu_pkg::data_t exp_v;
		mcu_pkg::data_t rd;
		string          name;

		RSTN      <= 1'b0;
		wb_cyc    <= 1'b0;
		wb_stb    <= 1'b0;
		wb_we     <= 1'b0;
		wb_adr    <= '0;
		wb_dat_w  <= '0;
		key_game  <= '0;
		lfsr_q    = 32'h2577e3fa;
		last_rand = '0;
		$readmemh("tests/mcu_periph_vectors.txt", vec_mem);

		repeat (5) @(posedge clk_ext8m);
		RSTN <= 1'b1;
		@(negedge clk_ext8m);
		check_value("reset ack", '0, {31'b0, wb_ack});
		check_value("reset int_o", '0, {31'b0, int_irq});

		n    = 0;
		done = 1'b0;
		while (!done && n < MAX_VEC)
		begin
			op    = vec_mem[4*n];
			adr   = mcu_pkg::addr_t'(vec_mem[4*n+1]);
			dat   = vec_mem[4*n+2];
			exp_v = vec_mem[4*n+3];
			name  = $sformatf("vector %0d at %h", n, adr);
			case (op)
				32'h0: bus_access(1'b1, adr, dat, name, rd);
				32'h1:
				begin
					bus_access(1'b0, adr, '0, name, rd);
					check_value(name, exp_v, rd);
				end
				32'h2:
				begin
					draw_word(last_rand);
					bus_access(1'b1, adr, last_rand, name, rd);
					bus_access(1'b0, adr, '0, name, rd);
					check_value(name, last_rand & exp_v, rd);  // Column holds the kept bits
				end
				32'h3: poll_reg(adr, exp_v, int'(dat), name);
				32'h4:
				begin
					@(posedge clk_ext8m);
					key_game <= dat[15:0];
				end
				32'h5:
				begin
					@(negedge clk_ext8m);
					check_value({name, " int_o"}, exp_v, {31'b0, int_irq});
				end
				32'h6:
				begin
					@(negedge clk_ext8m);
					check_value({name, " score_o"}, last_rand, score);
				end
				32'hf: done = 1'b1;
				default: abort_run($sformatf("Unknown operation %h in vector %0d", op, n));
			endcase
			if (!done)
				n++;
		end

		check_value("bus handshake assertions", '0,
			mcu_pkg::data_t'(i_dut.u_bus_ctrl.i_bus_assert.fail_cnt));

		if (done && n > 0)
		begin
			$display("** PASS **");
			$finish;
		end
		else
			abort_run("The vector file is missing or has no end marker");
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/mcu_pkg.sv
rtl/periph_bus_ctrl.sv
rtl/hpet_timer.sv
rtl/int_confreg.sv
rtl/game_regs.sv
rtl/mcu_periph_top.sv
tests/mcu_periph_assertions.sv
tests/tb_mcu_periph.sv
